// File: include/core_config.svh
// Core slice configuration
// Widths fixed by the 32-bit instruction format

`ifndef CORE_CONFIG_SVH
`define CORE_CONFIG_SVH

// Register and result width
`define DATA_WIDTH 32

// Architectural register file
`define REG_COUNT 16
`define REG_IDX_WIDTH 4	// Enough for REG_COUNT entries

// Instruction word fields
`define OPCODE_WIDTH 4
`define IMM_WIDTH 16	// Sign extended to DATA_WIDTH at decode

`endif

// File: design/isa_pkg.sv
// Instruction set of the core slice
// Opcode encoding and the raw 32-bit instruction word layout

`default_nettype none

`include "core_config.svh"

package isa_pkg;

	// Codes 10 to 15 are illegal and decode as OP_NOP
	typedef enum logic [`OPCODE_WIDTH-1:0] {
		OP_NOP  = 'd0,	// Retires without a register write
		OP_ADD  = 'd1,
		OP_SUB  = 'd2,
		OP_AND  = 'd3,
		OP_OR   = 'd4,
		OP_XOR  = 'd5,
		OP_SHL  = 'd6,	// Shift by low 5 bits of rs2
		OP_SHR  = 'd7,	// Logical right shift
		OP_LDI  = 'd8,	// Load sign extended immediate
		OP_HALT = 'd9	// Stops all later retirement
	} opcode_t;

	// Raw instruction word, most significant field first
	typedef struct packed {
		logic [`OPCODE_WIDTH-1:0] opcode;	// Raw code, may be illegal
		logic [`REG_IDX_WIDTH-1:0] rd;	// Destination
		logic [`REG_IDX_WIDTH-1:0] rs1;	// First source
		logic [`REG_IDX_WIDTH-1:0] rs2;	// Second source
		logic [`IMM_WIDTH-1:0] imm;	// Only LDI uses it
	} instr_word_t;

endpackage

`default_nettype wire

// File: design/pipe_pkg.sv
// Pipeline payloads of the core slice
// Structs passed between stages and out to the result port

`default_nettype none

`include "core_config.svh"

package pipe_pkg;
	import isa_pkg::*;

	// Decode to execute
	typedef struct packed {
		opcode_t op;	// Always legal here
		logic [`REG_IDX_WIDTH-1:0] rd;
		logic [`REG_IDX_WIDTH-1:0] rs1;
		logic [`REG_IDX_WIDTH-1:0] rs2;
		logic [`DATA_WIDTH-1:0] imm;	// Already sign extended
		logic writes_reg;	// ADD through LDI
	} decoded_instr_t;

	// Execute to writeback, also the bypass source
	typedef struct packed {
		logic valid;
		logic [`REG_IDX_WIDTH-1:0] rd;
		logic [`DATA_WIDTH-1:0] value;	// ALU or immediate result
		logic writes_reg;
		logic is_halt;
	} exec_result_t;

	// Retired register write seen at the top level
	typedef struct packed {
		logic en;	// Low for NOP, HALT and after halt
		logic [`REG_IDX_WIDTH-1:0] reg_idx;
		logic [`DATA_WIDTH-1:0] value;
	} writeback_t;

endpackage

`default_nettype wire

// File: design/decode_stage.sv
// Decode stage
// Splits the instruction word, squashes illegal opcodes and registers the result

`default_nettype none
`timescale 1ns/100ps

`include "core_config.svh"

module decode_stage
	import isa_pkg::*, pipe_pkg::*;
	(input                  clk,
	input                   reset,
	input logic             instr_valid,
	input instr_word_t      instr,
	output logic            dec_valid,
	output decoded_instr_t  dec);

	opcode_t next_op;
	logic op_legal;
	decoded_instr_t next_dec;

	// Anything above HALT is outside the ISA
	assign op_legal = instr.opcode <= OP_HALT;
	assign next_op = op_legal ? opcode_t'(instr.opcode) : OP_NOP;

	always_comb
	begin
		next_dec.op = next_op;
		next_dec.rd = instr.rd;
		next_dec.rs1 = instr.rs1;
		next_dec.rs2 = instr.rs2;
		next_dec.imm = {{(`DATA_WIDTH - `IMM_WIDTH){instr.imm[`IMM_WIDTH-1]}}, instr.imm};	// Sign extend
		next_dec.writes_reg = next_op inside {[OP_ADD:OP_LDI]};	// Not NOP or HALT
	end

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
			dec_valid <= 1'b0;
		else
			dec_valid <= instr_valid;	// One slot per strobe
	end

	// Payload only moves with a new instruction
	always_ff @(posedge clk)
	begin
		if (instr_valid)
			dec <= next_dec;
	end
endmodule

`default_nettype wire

// File: design/int_execute_stage.sv
// Integer execute stage
// Picks operands with bypass from its own result and registers the ALU output

`default_nettype none
`timescale 1ns/100ps

`include "core_config.svh"

module int_execute_stage
	import isa_pkg::*, pipe_pkg::*;
	(input                               clk,
	input                                reset,
	input logic                          dec_valid,
	input decoded_instr_t                dec,
	output logic [`REG_IDX_WIDTH-1:0]    rs1_idx,
	output logic [`REG_IDX_WIDTH-1:0]    rs2_idx,
	input logic [`DATA_WIDTH-1:0]        rs1_data,
	input logic [`DATA_WIDTH-1:0]        rs2_data,
	output exec_result_t                 ex);

	localparam SHAMT_WIDTH = $clog2(`DATA_WIDTH);	// 5 for 32-bit data

	logic ex_forwards;
	logic bypass_a;
	logic bypass_b;
	logic [`DATA_WIDTH-1:0] operand_a;
	logic [`DATA_WIDTH-1:0] operand_b;
	logic [SHAMT_WIDTH-1:0] shamt;
	logic [`DATA_WIDTH-1:0] result;

	// Register file read ports, answered combinationally
	assign rs1_idx = dec.rs1;
	assign rs2_idx = dec.rs2;

	// Result in ex is one write behind the register file
	assign ex_forwards = ex.valid && ex.writes_reg;
	assign bypass_a = ex_forwards && (ex.rd == dec.rs1);
	assign bypass_b = ex_forwards && (ex.rd == dec.rs2);

	assign operand_a = bypass_a ? ex.value : rs1_data;
	assign operand_b = bypass_b ? ex.value : rs2_data;
	assign shamt = operand_b[SHAMT_WIDTH-1:0];	// Upper bits ignored

	always_comb
	begin
		case (dec.op)
			OP_ADD: result = operand_a + operand_b;
			OP_SUB: result = operand_a - operand_b;
			OP_AND: result = operand_a & operand_b;
			OP_OR: result = operand_a | operand_b;
			OP_XOR: result = operand_a ^ operand_b;
			OP_SHL: result = operand_a << shamt;
			OP_SHR: result = operand_a >> shamt;	// Zero fill
			OP_LDI: result = dec.imm;
			default: result = '0;	// NOP and HALT write nothing
		endcase
	end

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
			ex <= '0;
		else
		begin
			ex.valid <= dec_valid;
			ex.rd <= dec.rd;
			ex.value <= result;
			ex.writes_reg <= dec.writes_reg;
			ex.is_halt <= dec.op == OP_HALT;
		end
	end
endmodule

`default_nettype wire

// File: design/writeback_stage.sv
// Writeback stage
// Owns the register file, retires results and keeps the sticky halt

`default_nettype none
`timescale 1ns/100ps

`include "core_config.svh"

module writeback_stage
	import pipe_pkg::*;
	(input                               clk,
	input                                reset,
	input exec_result_t                  ex,
	input logic [`REG_IDX_WIDTH-1:0]     rs1_idx,
	input logic [`REG_IDX_WIDTH-1:0]     rs2_idx,
	output logic [`DATA_WIDTH-1:0]       rs1_data,
	output logic [`DATA_WIDTH-1:0]       rs2_data,
	output writeback_t                   wb,
	output logic                         perf_instruction_retire,
	output logic                         processor_halt);

	logic [`DATA_WIDTH-1:0] regs[`REG_COUNT];
	logic retire_en;
	logic reg_write_en;

	// Two asynchronous read ports for execute
	assign rs1_data = regs[rs1_idx];
	assign rs2_data = regs[rs2_idx];

	// Nothing retires once halted, including the slot behind HALT
	assign retire_en = ex.valid && !processor_halt;
	assign reg_write_en = retire_en && ex.writes_reg;

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			for (int i = 0; i < `REG_COUNT; i++)
				regs[i] <= '0;	// Architectural state starts at zero
		end
		else if (reg_write_en)
			regs[ex.rd] <= ex.value;
	end

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			wb <= '0;
			perf_instruction_retire <= 1'b0;
			processor_halt <= 1'b0;
		end
		else
		begin
			wb.en <= reg_write_en;	// Same edge as the file write
			wb.reg_idx <= ex.rd;
			wb.value <= ex.value;
			perf_instruction_retire <= retire_en;	// NOPs count too
			if (retire_en && ex.is_halt)
				processor_halt <= 1'b1;	// Held until reset
		end
	end
endmodule

`default_nettype wire

// File: design/core.sv
// In-order integer core slice
// Decode, execute and writeback stages with a forwarding path from execute

`default_nettype none
`timescale 1ns/100ps

`include "core_config.svh"

module core
	import isa_pkg::*, pipe_pkg::*;
	(input                   clk,
	input                    reset,
	input logic              instr_valid,
	input instr_word_t       instr,
	output writeback_t       wb,
	output logic             perf_instruction_retire,
	output logic             processor_halt);

	// Decode to execute
	logic dec_valid;
	decoded_instr_t dec;

	// Execute to writeback
	exec_result_t ex;

	// Register file read ports
	logic [`REG_IDX_WIDTH-1:0] rs1_idx;
	logic [`REG_IDX_WIDTH-1:0] rs2_idx;
	logic [`DATA_WIDTH-1:0] rs1_data;
	logic [`DATA_WIDTH-1:0] rs2_data;

	// Sampling edge k lands in dec
	decode_stage decode_stage(.*);

	// Edge k+1 lands in ex
	int_execute_stage int_execute_stage(.*);

	// Edge k+2 retires
	writeback_stage writeback_stage(.*);
endmodule

`default_nettype wire

// File: testbench/core_chk.sv
// Core slice bound checker
// Retire, writeback and halt relations on the top-level outputs

`default_nettype none
`timescale 1ns/100ps

module core_chk
	import pipe_pkg::*;
	(input               clk,
	input                reset,
	input writeback_t    wb,
	input logic          perf_instruction_retire,
	input logic          processor_halt);

	// Halt is sticky until reset
	property halt_sticky;
		@(posedge clk) disable iff (reset)
			processor_halt |=> processor_halt;
	endproperty

	// A register write is always a retirement
	property write_is_retire;
		@(posedge clk) disable iff (reset)
			wb.en |-> perf_instruction_retire;
	endproperty

	// HALT's own pulse is the last one
	property quiet_after_halt;
		@(posedge clk) disable iff (reset)
			processor_halt |=> !perf_instruction_retire;
	endproperty

	halt_sticky_a: assert property (halt_sticky)
		else $error("processor_halt fell without reset");
	write_is_retire_a: assert property (write_is_retire)
		else $error("wb.en high without a retire pulse");
	quiet_after_halt_a: assert property (quiet_after_halt)
		else $error("retire pulse after the core halted");
endmodule

`default_nettype wire

// File: testbench/core_tb.sv
// Core slice testbench
// Random instruction stream against an in-order register model

`default_nettype none
`timescale 1ns/100ps

`include "core_config.svh"

module core_tb
	import isa_pkg::*, pipe_pkg::*;
	();

	localparam int N_INSTR = 2000;	// HALT is the last one
	localparam int N_AFTER_HALT = 8;	// Must all be dropped
	localparam int TIMEOUT_CYCLES = 4000;	// About 2900 expected

	// One expected retirement
	typedef struct packed {
		logic [31:0] retire_cycle;	// Edge count at which it shows
		writeback_t wb;
		logic halt;
	} expect_t;

	logic clk;
	logic reset;
	logic instr_valid;
	instr_word_t instr;
	writeback_t wb;
	logic perf_instruction_retire;
	logic processor_halt;

	int unsigned cycles;	// Rising edges seen so far
	expect_t exp_q[$];
	logic [`DATA_WIDTH-1:0] model_regs[`REG_COUNT];
	logic model_halted;	// HALT issued, rest is ignored
	logic exp_halt;

	core core_i(.*);

	bind core core_chk core_chk_i(
		.clk(clk),
		.reset(reset),
		.wb(wb),
		.perf_instruction_retire(perf_instruction_retire),
		.processor_halt(processor_halt));

	always #2 clk = ~clk;	// 4 ns period

	always @(posedge clk)
	begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT_CYCLES)
		begin
			$display("Run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("TESTS FAILED");
			$fatal(1, "timeout");
		end
	end

	// ISA semantics for the reference model
	function automatic logic [`DATA_WIDTH-1:0] predict_value(input logic [3:0] code,
		input logic [`DATA_WIDTH-1:0] a, input logic [`DATA_WIDTH-1:0] b,
		input logic [`IMM_WIDTH-1:0] imm);
		case (code)
			OP_ADD: return a + b;
			OP_SUB: return a - b;
			OP_AND: return a & b;
			OP_OR: return a | b;
			OP_XOR: return a ^ b;
			OP_SHL: return a << b[4:0];
			OP_SHR: return a >> b[4:0];	// Logical
			OP_LDI: return {{(`DATA_WIDTH - `IMM_WIDTH){imm[`IMM_WIDTH-1]}}, imm};
			default: return '0;
		endcase
	endfunction

	task automatic report_mismatch(input string name, input logic [63:0] expected,
		input logic [63:0] actual);
		$display("[FAIL] t=%0t %s expected %h actual %h", $time, name, expected, actual);
		$display("TESTS FAILED");
		$fatal(1, "mismatch on %s", name);
	endtask

	// Drive one valid instruction and update the model in program order
	task automatic issue(input instr_word_t word);
		expect_t e;
		logic [`DATA_WIDTH-1:0] value;
		instr_valid <= 1'b1;
		instr <= word;
		if (!model_halted)
		begin
			value = predict_value(word.opcode, model_regs[word.rs1], model_regs[word.rs2],
				word.imm);
			e.retire_cycle = cycles + 4;	// Sampled next edge, retires two later
			e.wb.en = (word.opcode >= OP_ADD) && (word.opcode <= OP_LDI);
			e.wb.reg_idx = word.rd;
			e.wb.value = value;
			e.halt = word.opcode == OP_HALT;
			if (e.wb.en)
				model_regs[word.rd] = value;
			if (e.halt)
				model_halted = 1'b1;
			exp_q.push_back(e);
		end
	endtask

	function automatic instr_word_t random_instr();
		instr_word_t w;
		logic [3:0] code;
		code = $urandom % 15;
		if (code >= OP_HALT)
			code = code + 1;	// Skip HALT, keep illegal codes
		w.opcode = code;
		w.rd = $urandom % 4;	// r0 to r3 for dense hazards
		w.rs1 = $urandom % 4;
		w.rs2 = $urandom % 4;
		w.imm = $urandom;
		return w;
	endfunction

	// Outputs settle well before the falling edge
	task automatic check_outputs();
		expect_t e;
		logic exp_retire;
		writeback_t exp_wb;
		exp_retire = 1'b0;
		exp_wb = '0;
		if (exp_q.size() != 0 && exp_q[0].retire_cycle == cycles)
		begin
			e = exp_q.pop_front();
			exp_retire = 1'b1;
			exp_wb = e.wb;
			if (e.halt)
				exp_halt = 1'b1;	// Rises with HALT's pulse
		end
		assert (perf_instruction_retire === exp_retire)
			else report_mismatch("perf_instruction_retire", exp_retire, perf_instruction_retire);
		assert (wb.en === exp_wb.en)
			else report_mismatch("wb.en", exp_wb.en, wb.en);
		if (exp_wb.en)
			assert (wb === exp_wb)
				else report_mismatch("wb", exp_wb, wb);
		assert (processor_halt === exp_halt)
			else report_mismatch("processor_halt", exp_halt, processor_halt);
	endtask

	always @(negedge clk)
		check_outputs();

	initial
	begin
		instr_word_t halt_word;
		clk = 1'b0;
		reset = 1'b1;
		instr_valid = 1'b0;
		instr = '0;
		cycles = 0;
		model_halted = 1'b0;
		exp_halt = 1'b0;
		void'($urandom(621));
		for (int i = 0; i < `REG_COUNT; i++)
			model_regs[i] = '0;	// Matches reset state
		repeat (16) @(posedge clk);
		reset <= 1'b0;
		for (int n = 0; n < N_INSTR + N_AFTER_HALT; n++)
		begin
			@(posedge clk);
			while (($urandom % 10) >= 7)
			begin
				instr_valid <= 1'b0;	// Bubble, about 30%
				instr <= $urandom;
				@(posedge clk);
			end
			if (n == N_INSTR - 1)
			begin
				halt_word = random_instr();
				halt_word.opcode = OP_HALT;
				issue(halt_word);
			end
			else
				issue(random_instr());
		end
		@(posedge clk);
		instr_valid <= 1'b0;
		while (exp_q.size() != 0)
			@(posedge clk);
		repeat (8) @(posedge clk);	// Watch for stray retires
		$display("TESTS PASSED");
		$finish;
	end
endmodule

`default_nettype wire

// File: core_slice.f
+incdir+include
design/isa_pkg.sv
design/pipe_pkg.sv
design/decode_stage.sv
design/int_execute_stage.sv
design/writeback_stage.sv
design/core.sv
testbench/core_chk.sv
testbench/core_tb.sv
